// ==== rtl/eth_loopback_defines.svh ====
// Framing constants for a GMII loopback without FCS; all lengths count data bytes only
`ifndef ETH_LOOPBACK_DEFINES_SVH
`define ETH_LOOPBACK_DEFINES_SVH

// Preamble and start-of-frame delimiter octets
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE      8'hd5

// Preamble octets sent ahead of the SFD
`define ETH_PREAMBLE_LEN  7

// Minimum idle cycles between transmitted frames
`define ETH_IFG           12

// 64 byte minimum frame less the 4 byte FCS that is not generated
`define ETH_MIN_DATA_LEN  60

// Longest accepted frame, standard size
`define ETH_MAX_PKT_LEN   1518

// Frame FIFO entries, one data byte each
`define ETH_FIFO_DEPTH    2048

`endif

// ==== rtl/eth_loopback_pkg.sv ====
// Shared datapath types for the loopback; frame lengths are limited to 16 bits
package eth_loopback_pkg;

    // One GMII data octet
    typedef logic [7:0] eth_byte_t;

    // Byte counter wide enough for any frame up to 64k bytes
    typedef logic [15:0] frame_len_t;

    // FIFO word: data byte plus end of frame marker
    typedef struct packed {
        eth_byte_t data;
        logic      last;
    } fifo_entry_t;

endpackage

// ==== rtl/gmii_rx_framer.sv ====
// GMII receive framer; 1000 Mb/s only, no clock enable, trailing bytes (FCS) pass as data
`timescale 1ns/1ns
`include "eth_loopback_defines.svh"

module gmii_rx_framer (
    input  logic                        clk_125mhz,
    input  logic                        rst_n,
    input  eth_loopback_pkg::eth_byte_t gmii_rxd,
    input  logic                        gmii_rx_dv,
    input  logic                        gmii_rx_er,
    output logic                        rx_valid,
    output eth_loopback_pkg::eth_byte_t rx_data,
    output logic                        rx_last,
    output logic                        rx_bad
);

    import eth_loopback_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA
    } rx_state_t;

    rx_state_t  state;
    eth_byte_t  rxd_q;
    logic       rx_dv_q;
    logic       rx_er_q;
    eth_byte_t  hold_data;
    logic       hold_valid;
    frame_len_t byte_cnt;
    logic       frame_err;

    // GMII input register
    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            rxd_q   <= '0;
            rx_dv_q <= 1'b0;
            rx_er_q <= 1'b0;
        end else begin
            rxd_q   <= gmii_rxd;
            rx_dv_q <= gmii_rx_dv;
            rx_er_q <= gmii_rx_er;
        end
    end

    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            hold_data  <= '0;
            hold_valid <= 1'b0;
            byte_cnt   <= '0;
            frame_err  <= 1'b0;
            rx_valid   <= 1'b0;
            rx_data    <= '0;
            rx_last    <= 1'b0;
            rx_bad     <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_last  <= 1'b0;
            rx_bad   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    hold_valid <= 1'b0;
                    byte_cnt   <= '0;
                    frame_err  <= rx_dv_q && rx_er_q;
                    if (rx_dv_q && rxd_q == `ETH_SFD_BYTE) begin
                        state <= ST_DATA;
                    end else if (rx_dv_q) begin
                        state <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    // Errors in the preamble still spoil the frame
                    frame_err <= frame_err || rx_er_q;
                    if (!rx_dv_q) begin
                        state <= ST_IDLE;
                    end else if (rxd_q == `ETH_SFD_BYTE) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rx_dv_q) begin
                        if (rx_er_q) begin
                            frame_err <= 1'b1;
                        end
                        if (byte_cnt == frame_len_t'(`ETH_MAX_PKT_LEN)) begin
                            // Oversize, byte is discarded
                            frame_err <= 1'b1;
                        end else begin
                            byte_cnt   <= byte_cnt + 1'b1;
                            hold_data  <= rxd_q;
                            hold_valid <= 1'b1;
                            rx_valid   <= hold_valid;
                            rx_data    <= hold_data;
                        end
                    end else begin
                        // End of frame, release the held byte as last
                        state      <= ST_IDLE;
                        hold_valid <= 1'b0;
                        rx_valid   <= hold_valid;
                        rx_data    <= hold_data;
                        rx_last    <= hold_valid;
                        rx_bad     <= hold_valid && frame_err;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Bad marker only on the closing byte, once rx_dv has fallen at the input
    a_bad_only_on_last: assert property (
        @(posedge clk_125mhz) disable iff (!rst_n)
        rx_bad |-> rx_valid && rx_last && !$past(gmii_rx_dv, 2)
    ) else $error("rx_bad raised outside a last byte");

endmodule

// ==== rtl/frame_fifo.sv ====
// Frame FIFO with commit and rollback; DEPTH is a power of two of at least 2, no ready to the writer
`timescale 1ns/1ns
`include "eth_loopback_defines.svh"

module frame_fifo #(
    parameter int DEPTH = `ETH_FIFO_DEPTH
) (
    input  logic                        clk_125mhz,
    input  logic                        rst_n,
    input  logic                        rx_valid,
    input  eth_loopback_pkg::eth_byte_t rx_data,
    input  logic                        rx_last,
    input  logic                        rx_bad,
    output logic                        ff_valid,
    output eth_loopback_pkg::eth_byte_t ff_data,
    output logic                        ff_last,
    input  logic                        ff_ready
);

    import eth_loopback_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // One extra bit to tell full from empty
    typedef logic [AW:0] ptr_t;

    fifo_entry_t mem [DEPTH];
    fifo_entry_t rd_entry;

    ptr_t wr_ptr;
    ptr_t wr_ptr_next;
    ptr_t commit_ptr;
    ptr_t rd_ptr;

    logic drop;
    logic full;
    logic wr_en;
    logic commit;
    logic rd_en;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // A frame that lost a byte is never written again
    assign wr_en       = rx_valid && !full && !drop;
    assign wr_ptr_next = wr_ptr + 1'b1;
    assign commit      = wr_en && rx_last && !rx_bad;

    // Write side
    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            drop       <= 1'b0;
        end else if (rx_valid) begin
            if (rx_last) begin
                drop <= 1'b0;
                if (commit) begin
                    wr_ptr     <= wr_ptr_next;
                    commit_ptr <= wr_ptr_next;
                end else begin
                    // bad or overflowed frame, forget it
                    wr_ptr <= commit_ptr;
                end
            end else begin
                if (full) begin
                    drop <= 1'b1;
                end
                if (wr_en) begin
                    wr_ptr <= wr_ptr_next;
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= '{data: rx_data, last: rx_last};
        end
    end

    // Read side with registered output, only committed bytes are visible
    assign rd_en = (rd_ptr != commit_ptr) && (!ff_valid || ff_ready);

    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            ff_valid <= 1'b0;
        end else if (rd_en) begin
            rd_ptr   <= rd_ptr + 1'b1;
            ff_valid <= 1'b1;
        end else if (ff_ready) begin
            ff_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rd_en) begin
            rd_entry <= mem[rd_ptr[AW-1:0]];
        end
    end

    assign ff_data = rd_entry.data;
    assign ff_last = rd_entry.last;

    // Committed level wraps past DEPTH if the reader overtakes the commit point
    a_rd_behind_commit: assert property (
        @(posedge clk_125mhz) disable iff (!rst_n)
        ptr_t'(commit_ptr - rd_ptr) <= ptr_t'(DEPTH)
    ) else $error("read pointer passed commit pointer");

    a_hold_stable: assert property (
        @(posedge clk_125mhz) disable iff (!rst_n)
        ff_valid && !ff_ready |=> ff_valid && $stable(ff_data)
    ) else $error("ff_data changed while stalled");

endmodule

// ==== rtl/gmii_tx_framer.sv ====
// GMII transmit framer; no FCS is appended, padding counts data bytes only, tx_er not driven
`timescale 1ns/1ns
`include "eth_loopback_defines.svh"

module gmii_tx_framer (
    input  logic                        clk_125mhz,
    input  logic                        rst_n,
    input  logic                        cfg_tx_enable,
    input  logic                        ff_valid,
    input  eth_loopback_pkg::eth_byte_t ff_data,
    input  logic                        ff_last,
    output logic                        ff_ready,
    output eth_loopback_pkg::eth_byte_t gmii_txd,
    output logic                        gmii_tx_en
);

    import eth_loopback_pkg::*;

    localparam int GAP_W = $clog2(`ETH_IFG + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_PAD,
        ST_GAP
    } tx_state_t;

    tx_state_t        state;
    frame_len_t       byte_cnt;
    logic [GAP_W-1:0] gap_cnt;

    assign ff_ready = (state == ST_DATA);

    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            byte_cnt   <= '0;
            gap_cnt    <= '0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    // A started frame runs to the end even if enable drops
                    if (ff_valid && cfg_tx_enable) begin
                        state      <= ST_PREAMBLE;
                        byte_cnt   <= frame_len_t'(1);
                        gmii_txd   <= `ETH_PREAMBLE_BYTE;
                        gmii_tx_en <= 1'b1;
                    end
                end
                ST_PREAMBLE: begin
                    if (byte_cnt == frame_len_t'(`ETH_PREAMBLE_LEN)) begin
                        state    <= ST_DATA;
                        byte_cnt <= '0;
                        gmii_txd <= `ETH_SFD_BYTE;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                        gmii_txd <= `ETH_PREAMBLE_BYTE;
                    end
                end
                ST_DATA: begin
                    if (ff_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        gmii_txd <= ff_data;
                        if (ff_last) begin
                            gap_cnt <= '0;
                            if (byte_cnt + 1'b1 < frame_len_t'(`ETH_MIN_DATA_LEN)) begin
                                state <= ST_PAD;
                            end else begin
                                state <= ST_GAP;
                            end
                        end
                    end else begin
                        gmii_txd <= '0;
                    end
                end
                ST_PAD: begin
                    // Zero fill up to the minimum length
                    byte_cnt <= byte_cnt + 1'b1;
                    gmii_txd <= '0;
                    if (byte_cnt + 1'b1 == frame_len_t'(`ETH_MIN_DATA_LEN)) begin
                        state <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    if (gap_cnt == GAP_W'(`ETH_IFG - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data phase opens right after the delimiter goes out
    a_ready_in_frame: assert property (
        @(posedge clk_125mhz) disable iff (!rst_n)
        $rose(ff_ready) |-> gmii_tx_en && gmii_txd == `ETH_SFD_BYTE
    ) else $error("ff_ready outside the data phase");

    // Data phase closes once the last byte is taken
    a_ready_ends_on_last: assert property (
        @(posedge clk_125mhz) disable iff (!rst_n)
        ff_ready && ff_valid && ff_last |=> !ff_ready
    ) else $error("ff_ready still high after the last byte");

endmodule

// ==== rtl/eth_loopback.sv ====
// Single-port GMII loopback on one 125 MHz clock; no FCS, no flow control, whole-frame drops
`timescale 1ns/1ns
`include "eth_loopback_defines.svh"

module eth_loopback (
    input  logic                        clk_125mhz,
    input  logic                        rst_n,
    input  eth_loopback_pkg::eth_byte_t gmii_rxd,
    input  logic                        gmii_rx_dv,
    input  logic                        gmii_rx_er,
    output eth_loopback_pkg::eth_byte_t gmii_txd,
    output logic                        gmii_tx_en,
    input  logic                        cfg_tx_enable
);

    import eth_loopback_pkg::*;

    // Receive stream, no back-pressure
    logic      rx_valid;
    eth_byte_t rx_data;
    logic      rx_last;
    logic      rx_bad;

    // Committed frames toward the transmitter
    logic      ff_valid;
    eth_byte_t ff_data;
    logic      ff_last;
    logic      ff_ready;

    gmii_rx_framer u_rx_framer (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .rx_bad     (rx_bad)
    );

    frame_fifo #(
        .DEPTH (`ETH_FIFO_DEPTH)
    ) u_frame_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .rx_bad     (rx_bad),
        .ff_valid   (ff_valid),
        .ff_data    (ff_data),
        .ff_last    (ff_last),
        .ff_ready   (ff_ready)
    );

    gmii_tx_framer u_tx_framer (
        .clk_125mhz    (clk_125mhz),
        .rst_n         (rst_n),
        .cfg_tx_enable (cfg_tx_enable),
        .ff_valid      (ff_valid),
        .ff_data       (ff_data),
        .ff_last       (ff_last),
        .ff_ready      (ff_ready),
        .gmii_txd      (gmii_txd),
        .gmii_tx_en    (gmii_tx_en)
    );

endmodule

// ==== tests/tb_eth_loopback.sv ====
// Directed loopback tests; transmit carries no FCS, FIFO sizing follows ETH_FIFO_DEPTH
`timescale 1ns/1ns
`include "eth_loopback_defines.svh"

module tb_eth_loopback;

    import eth_loopback_pkg::*;

    localparam int MAX_CYCLES = 60000;
    localparam int WAIT_LIMIT = 4000;
    localparam int SETTLE     = 300;

    logic      clk_125mhz;
    logic      rst_n;
    eth_byte_t gmii_rxd;
    logic      gmii_rx_dv;
    logic      gmii_rx_er;
    eth_byte_t gmii_txd;
    logic      gmii_tx_en;
    logic      cfg_tx_enable;

    // Monitor results, one entry per transmitted frame
    eth_byte_t mon_bytes[$];
    eth_byte_t mon_sfd[$];
    int        mon_len[$];
    int        mon_pre[$];
    int        mon_gap[$];

    // Expected frames and the payload being built
    eth_byte_t exp_bytes[$];
    int        exp_len[$];
    eth_byte_t payload[$];

    int errors;
    int n_checks;
    int n_tests;
    int test_err_start;
    int cycles;

    eth_loopback u_eth_loopback (
        .clk_125mhz    (clk_125mhz),
        .rst_n         (rst_n),
        .gmii_rxd      (gmii_rxd),
        .gmii_rx_dv    (gmii_rx_dv),
        .gmii_rx_er    (gmii_rx_er),
        .gmii_txd      (gmii_txd),
        .gmii_tx_en    (gmii_tx_en),
        .cfg_tx_enable (cfg_tx_enable)
    );

    always #4 clk_125mhz = ~clk_125mhz;

    always @(posedge clk_125mhz) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Error: timeout, run still going after %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Transmit monitor, sampled mid-cycle where outputs are settled
    logic      in_frame;
    logic      in_data;
    int        pre_cnt;
    int        data_cnt;
    int        idle_cnt;
    int        frame_gap;
    eth_byte_t frame_sfd;

    always @(negedge clk_125mhz) begin
        if (gmii_tx_en) begin
            if (!in_frame) begin
                in_frame  = 1'b1;
                in_data   = 1'b0;
                pre_cnt   = 0;
                data_cnt  = 0;
                frame_gap = idle_cnt;
                frame_sfd = 8'h00;
            end
            if (in_data) begin
                mon_bytes.push_back(gmii_txd);
                data_cnt++;
            end else if (gmii_txd == `ETH_PREAMBLE_BYTE) begin
                pre_cnt++;
            end else begin
                // First non-preamble octet is taken as the delimiter
                frame_sfd = gmii_txd;
                in_data   = 1'b1;
            end
        end else begin
            if (in_frame) begin
                in_frame = 1'b0;
                idle_cnt = 0;
                mon_len.push_back(data_cnt);
                mon_pre.push_back(pre_cnt);
                mon_gap.push_back(frame_gap);
                mon_sfd.push_back(frame_sfd);
            end
            idle_cnt++;
        end
    end

    task automatic check(input string what, input int expected, input int actual);
        n_checks++;
        if (expected != actual) begin
            errors++;
            $display("FAIL at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    task automatic make_payload(input int len);
        int k;
        payload.delete();
        for (k = 0; k < len; k++) begin
            payload.push_back(eth_byte_t'($urandom));
        end
    endtask

    // Transmit output is the payload zero-filled to the minimum length
    task automatic expect_payload();
        int k;
        for (k = 0; k < payload.size(); k++) begin
            exp_bytes.push_back(payload[k]);
        end
        for (k = payload.size(); k < `ETH_MIN_DATA_LEN; k++) begin
            exp_bytes.push_back(8'h00);
        end
        exp_len.push_back(payload.size() < `ETH_MIN_DATA_LEN ?
                          `ETH_MIN_DATA_LEN : payload.size());
    endtask

    // err_at is a data byte index for rx_er, negative for none
    task automatic send_frame(input int err_at);
        int k;
        for (k = 0; k < `ETH_PREAMBLE_LEN; k++) begin
            @(negedge clk_125mhz);
            gmii_rxd   = `ETH_PREAMBLE_BYTE;
            gmii_rx_dv = 1'b1;
        end
        @(negedge clk_125mhz);
        gmii_rxd = `ETH_SFD_BYTE;
        for (k = 0; k < payload.size(); k++) begin
            @(negedge clk_125mhz);
            gmii_rxd   = payload[k];
            gmii_rx_er = (k == err_at);
        end
        @(negedge clk_125mhz);
        gmii_rxd   = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        repeat (11) @(negedge clk_125mhz);
    endtask

    task automatic wait_frames(input int n);
        int waited;
        waited = 0;
        while (mon_len.size() < n && waited < WAIT_LIMIT) begin
            @(negedge clk_125mhz);
            waited++;
        end
    endtask

    task automatic check_frames(input bit check_gap);
        int n;
        int f;
        int k;
        int len;
        int got_len;
        int gap;
        int err_before;
        n = exp_len.size();
        wait_frames(n);
        for (f = 0; f < n; f++) begin
            len = exp_len.pop_front();
            if (mon_len.size() == 0) begin
                errors++;
                $display("Error at %0t ns: expected frame missing (%0d of %0d)", $time, f + 1, n);
                for (k = 0; k < len; k++) begin
                    void'(exp_bytes.pop_front());
                end
            end else begin
                got_len = mon_len.pop_front();
                gap     = mon_gap.pop_front();
                check("frame length", len, got_len);
                check("preamble octets", `ETH_PREAMBLE_LEN, mon_pre.pop_front());
                check("start delimiter", `ETH_SFD_BYTE, mon_sfd.pop_front());
                if (check_gap) begin
                    check($sformatf("gap of %0d idle cycles below minimum", gap),
                          1, int'(gap >= `ETH_IFG));
                end
                // Compare bytes until the first mismatch, then drain the rest
                err_before = errors;
                for (k = 0; k < len || k < got_len; k++) begin
                    if (k < len && k < got_len && errors == err_before && len == got_len) begin
                        check($sformatf("data byte %0d", k), exp_bytes.pop_front(),
                              mon_bytes.pop_front());
                    end else begin
                        if (k < len) begin
                            void'(exp_bytes.pop_front());
                        end
                        if (k < got_len) begin
                            void'(mon_bytes.pop_front());
                        end
                    end
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        repeat (SETTLE) @(negedge clk_125mhz);
        check("unexpected extra frames", 0, mon_len.size());
        mon_bytes.delete();
        mon_sfd.delete();
        mon_len.delete();
        mon_pre.delete();
        mon_gap.delete();
        n_tests++;
        $display("test %-14s %s", name, (errors == test_err_start) ? "ok" : "failed");
        test_err_start = errors;
    endtask

    task automatic test_good_frame();
        check("transmit enable before first frame", 0, gmii_tx_en);
        check("frames before first frame", 0, mon_len.size());
        make_payload(100);
        expect_payload();
        send_frame(-1);
        check_frames(1'b0);
        end_test("good_frame");
    endtask

    task automatic test_padding();
        make_payload(20);
        expect_payload();
        send_frame(-1);
        check_frames(1'b0);
        end_test("padding");
    endtask

    task automatic test_bad_frame();
        make_payload(100);
        send_frame(50);
        make_payload(80);
        expect_payload();
        send_frame(-1);
        check_frames(1'b0);
        end_test("bad_frame");
    endtask

    task automatic test_length_limit();
        make_payload(`ETH_MAX_PKT_LEN + 1);
        send_frame(-1);
        make_payload(`ETH_MAX_PKT_LEN);
        expect_payload();
        send_frame(-1);
        check_frames(1'b0);
        end_test("length_limit");
    endtask

    task automatic test_full_fifo();
        int lens[4];
        int held;
        int i;
        lens = '{900, 900, 900, 200};
        held = 0;
        @(negedge clk_125mhz);
        cfg_tx_enable = 1'b0;
        for (i = 0; i < 4; i++) begin
            make_payload(lens[i]);
            // A frame fits only if it joins the bytes already held
            if (held + lens[i] <= `ETH_FIFO_DEPTH) begin
                expect_payload();
                held += lens[i];
            end
            send_frame(-1);
        end
        repeat (20) @(negedge clk_125mhz);
        check("frames sent while disabled", 0, mon_len.size());
        cfg_tx_enable = 1'b1;
        check_frames(1'b0);
        end_test("full_fifo");
    endtask

    task automatic test_gap();
        int i;
        // Frames queue in the FIFO so only the transmit gap separates them
        @(negedge clk_125mhz);
        cfg_tx_enable = 1'b0;
        for (i = 0; i < 3; i++) begin
            make_payload(64);
            expect_payload();
            send_frame(-1);
        end
        cfg_tx_enable = 1'b1;
        check_frames(1'b1);
        end_test("gap");
    endtask

    initial begin
        clk_125mhz     = 1'b0;
        rst_n          = 1'b0;
        gmii_rxd       = 8'h00;
        gmii_rx_dv     = 1'b0;
        gmii_rx_er     = 1'b0;
        cfg_tx_enable  = 1'b1;
        errors         = 0;
        n_checks       = 0;
        n_tests        = 0;
        test_err_start = 0;
        cycles         = 0;
        in_frame       = 1'b0;
        in_data        = 1'b0;
        idle_cnt       = 0;
        void'($urandom(32'hfd0c5c71));
        repeat (8) @(negedge clk_125mhz);
        rst_n = 1'b1;
        repeat (4) @(negedge clk_125mhz);

        test_good_frame();
        test_padding();
        test_bad_frame();
        test_length_limit();
        test_full_fifo();
        test_gap();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== eth_loopback.f ====
+incdir+rtl
rtl/eth_loopback_pkg.sv
rtl/gmii_rx_framer.sv
rtl/frame_fifo.sv
rtl/gmii_tx_framer.sv
rtl/eth_loopback.sv
tests/tb_eth_loopback.sv

// ==== Bender.yml ====
package:
  name: eth_loopback

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/eth_loopback_pkg.sv
      - rtl/gmii_rx_framer.sv
      - rtl/frame_fifo.sv
      - rtl/gmii_tx_framer.sv
      - rtl/eth_loopback.sv
      - target: simulation
        files:
          - tests/tb_eth_loopback.sv
